// File: Bender.yml
package:
  name: tcp_rx

sources:
  - src/tcp_rx_pkg.sv
  - src/tcp_hdr_parser.sv
  - src/tcp_opt_parser.sv
  - src/pl_buf_arbiter.sv
  - src/pl_buf_ram.sv
  - src/tcp_rx_top.sv
  - target: test
    files:
      - tb/tcp_rx_tb.sv

// File: src/pl_buf_arbiter.sv
`default_nettype none

module pl_buf_arbiter (
	input  wire                               clk,
	input  wire                               fsm_rst,
	input  wire                               wr_req,
	input  wire  [tcp_rx_pkg::PL_ADDR_W-1:0]  wr_addr,
	input  wire  [7:0]                        wr_data,
	input  wire                               rd_req,
	input  wire  [tcp_rx_pkg::PL_ADDR_W-1:0]  rd_addr,
	input  wire  [7:0]                        mem_rdata,
	output logic                              mem_we,
	output logic [tcp_rx_pkg::PL_ADDR_W-1:0]  mem_addr,
	output logic [7:0]                        mem_wdata,
	output logic                              rd_valid,
	output logic [7:0]                        rd_data
);

	logic rd_grant;
	// this request already got its one grant
	logic rd_served;

	// writer has fixed priority
	assign rd_grant  = rd_req && !wr_req && !rd_served;
	assign mem_we    = wr_req;
	assign mem_addr  = wr_req ? wr_addr : rd_addr;
	assign mem_wdata = wr_data;

	// memory output lines up with the registered grant
	assign rd_data = mem_rdata;

	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			rd_valid  <= 1'b0;
			rd_served <= 1'b0;
		end else begin
			rd_valid  <= rd_grant;
			// rearmed once the host drops rd_req
			rd_served <= rd_req && (rd_served || rd_grant);
		end
	end

endmodule

`default_nettype wire

// File: src/pl_buf_ram.sv
`default_nettype none

module pl_buf_ram (
	input  wire                              clk,
	input  wire                              we,
	input  wire  [tcp_rx_pkg::PL_ADDR_W-1:0] addr,
	input  wire  [7:0]                       wdata,
	output logic [7:0]                       rdata
);
	import tcp_rx_pkg::*;

	logic [7:0] mem [PL_BUF_DEPTH];

	// read returns the old contents on a write cycle
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// File: src/tcp_hdr_parser.sv
`default_nettype none

module tcp_hdr_parser (
	input  wire         clk,
	input  wire         fsm_rst,
	input  wire  [7:0]  rx_d,
	input  wire         rx_v,
	input  wire         rx_sof,
	input  wire         rx_eof,
	input  wire         rx_err,
	input  wire  [7:0]  ip_proto,
	input  wire  [15:0] ip_pl_len,
	input  wire  [15:0] local_port,
	output logic [15:0] src_port,
	output logic [15:0] dst_port,
	output logic [31:0] seq_num,
	output logic [31:0] ack_num,
	output logic [8:0]  flags,
	output logic [15:0] win_size,
	output logic [15:0] urg_ptr,
	output logic        hdr_v,
	output logic        pkt_done,
	output logic        err,
	output logic [15:0] pl_len,
	output logic        opt_en,
	output logic        frame_clr,
	output logic        wr_req,
	output logic [tcp_rx_pkg::PL_ADDR_W-1:0] wr_addr,
	output logic [7:0]  wr_data
);
	import tcp_rx_pkg::*;

	// bytes 0..18 of the header, newest in [0]
	logic [MIN_HDR_LEN-2:0][7:0] hdr_sr;
	logic [15:0] byte_cnt;
	logic [15:0] idx;
	logic [15:0] hdr_len;
	logic [5:0]  offset_bytes;
	logic        active;
	logic        acc;
	logic        tcp_ok;
	logic        port_ok;
	logic        seg_ok;
	logic        err_seen;
	logic        in_payload;
	logic        seg_good;

	assign acc    = rx_v && (rx_sof || active);
	assign idx    = rx_sof ? 16'd0 : byte_cnt;
	assign tcp_ok = (ip_proto == TCP_PROTO);
	assign seg_ok = tcp_ok && port_ok;

	// an offset below five words is treated as a bare header
	assign hdr_len = (offset_bytes > 6'(MIN_HDR_LEN)) ? {10'd0, offset_bytes} :
		16'(MIN_HDR_LEN);

	assign in_payload = (idx >= hdr_len);
	assign opt_en     = active && seg_ok && (idx >= 16'(MIN_HDR_LEN)) && (idx < hdr_len);

	// count matches, no upstream error, and the header was complete
	assign seg_good = ((idx + 16'd1) == ip_pl_len) && !err_seen && !rx_err &&
		(idx >= hdr_len - 16'd1);

	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			byte_cnt     <= 16'd0;
			active       <= 1'b0;
			port_ok      <= 1'b0;
			err_seen     <= 1'b0;
			offset_bytes <= 6'd0;
			pl_len       <= 16'd0;
			hdr_v        <= 1'b0;
			pkt_done     <= 1'b0;
			err          <= 1'b0;
			frame_clr    <= 1'b0;
			wr_req       <= 1'b0;
		end else begin
			hdr_v     <= 1'b0;
			pkt_done  <= 1'b0;
			err       <= 1'b0;
			wr_req    <= 1'b0;
			frame_clr <= acc && (rx_sof || rx_eof);

			if (active && rx_err) begin
				err_seen <= 1'b1;
			end

			if (acc) begin
				// new segment
				if (rx_sof) begin
					port_ok  <= 1'b0;
					err_seen <= rx_err;
					pl_len   <= 16'd0;
				end

				byte_cnt <= idx + 16'd1;
				active   <= !rx_eof;

				if (idx == 16'(OFFSET_BYTE_POS)) begin
					offset_bytes <= {rx_d[7:4], 2'b00};
				end

				// destination port complete at byte 3
				if (idx == 16'd3) begin
					port_ok <= ({hdr_sr[0], rx_d} == local_port);
				end

				if (idx == hdr_len - 16'd1) begin
					hdr_v <= seg_ok;
				end

				if (seg_ok && in_payload) begin
					pl_len <= pl_len + 16'd1;
					wr_req <= (pl_len < 16'(PL_BUF_DEPTH));
				end

				if (rx_eof) begin
					port_ok <= 1'b0;
					if (seg_ok) begin
						pkt_done <= seg_good;
						err      <= !seg_good;
					end
				end
			end
		end
	end

	// header capture and write payload
	always_ff @(posedge clk) begin
		if (acc) begin
			hdr_sr <= {hdr_sr[MIN_HDR_LEN-3:0], rx_d};
			if (idx == 16'(MIN_HDR_LEN - 1) && seg_ok) begin
				src_port <= hdr_sr[18:17];
				dst_port <= hdr_sr[16:15];
				seq_num  <= hdr_sr[14:11];
				ack_num  <= hdr_sr[10:7];
				// ns bit sits at the bottom of the offset byte
				flags    <= {hdr_sr[6][0], hdr_sr[5]};
				win_size <= hdr_sr[4:3];
				urg_ptr  <= {hdr_sr[0], rx_d};
			end
			wr_addr <= pl_len[PL_ADDR_W-1:0];
			wr_data <= rx_d;
		end
	end

endmodule

`default_nettype wire

// File: src/tcp_opt_parser.sv
`default_nettype none

module tcp_opt_parser (
	input  wire                   clk,
	input  wire                   fsm_rst,
	input  wire  [7:0]            rx_d,
	input  wire                   rx_v,
	input  wire                   opt_en,
	input  wire                   frame_clr,
	output logic                  mss_pres,
	output logic [15:0]           mss,
	output logic                  win_pres,
	output logic [7:0]            win_scale,
	output logic                  sack_perm_pres,
	output logic                  sack_pres,
	output logic [2:0]            sack_blocks,
	output logic                  ts_pres,
	output tcp_rx_pkg::opt_word_u opt_word
);
	import tcp_rx_pkg::*;

	logic [1:0]  field;
	logic [7:0]  cur_kind;
	logic [7:0]  data_rem;
	logic        walk_end;
	// results belong to the frame that is ending
	logic        held;
	logic [55:0] opt_sr;
	logic [63:0] opt_next;
	logic        step;

	assign step     = opt_en && rx_v && !walk_end && !frame_clr;
	assign opt_next = {opt_sr, rx_d};

	// walk state and presence flags
	always_ff @(posedge clk) begin
		if (fsm_rst) begin
			field          <= OPT_FIELD_KIND;
			walk_end       <= 1'b0;
			held           <= 1'b0;
			mss_pres       <= 1'b0;
			win_pres       <= 1'b0;
			sack_perm_pres <= 1'b0;
			sack_pres      <= 1'b0;
			ts_pres        <= 1'b0;
			sack_blocks    <= 3'd0;
		end else if (frame_clr) begin
			field    <= OPT_FIELD_KIND;
			walk_end <= 1'b0;
			held     <= 1'b0;
			// keep results across the end pulse, drop them at the next start
			if (!held) begin
				mss_pres       <= 1'b0;
				win_pres       <= 1'b0;
				sack_perm_pres <= 1'b0;
				sack_pres      <= 1'b0;
				ts_pres        <= 1'b0;
				sack_blocks    <= 3'd0;
			end
		end else if (step) begin
			held <= 1'b1;
			case (field)
				OPT_FIELD_KIND: begin
					case (rx_d)
						OPT_END:       walk_end <= 1'b1;
						OPT_NOP:       field <= OPT_FIELD_KIND;
						OPT_MSS: begin
							mss_pres <= 1'b1;
							field    <= OPT_FIELD_LEN;
						end
						OPT_WIN: begin
							win_pres <= 1'b1;
							field    <= OPT_FIELD_LEN;
						end
						OPT_SACK_PERM: begin
							sack_perm_pres <= 1'b1;
							field          <= OPT_FIELD_LEN;
						end
						OPT_SACK: begin
							sack_pres <= 1'b1;
							field     <= OPT_FIELD_LEN;
						end
						OPT_TS: begin
							ts_pres <= 1'b1;
							field   <= OPT_FIELD_LEN;
						end
						// unknown kind, length cannot be trusted
						default:       walk_end <= 1'b1;
					endcase
				end
				OPT_FIELD_LEN: begin
					if (cur_kind == OPT_SACK) begin
						case (rx_d)
							8'd10:   sack_blocks <= 3'd1;
							8'd18:   sack_blocks <= 3'd2;
							8'd26:   sack_blocks <= 3'd3;
							8'd34:   sack_blocks <= 3'd4;
							default: sack_blocks <= 3'd0;
						endcase
					end
					// malformed length stops the walk
					if (rx_d < 8'd2) begin
						walk_end <= 1'b1;
					end
					field <= (rx_d > 8'd2) ? OPT_FIELD_DATA : OPT_FIELD_KIND;
				end
				OPT_FIELD_DATA: begin
					if (data_rem == 8'd1) begin
						field <= OPT_FIELD_KIND;
					end
				end
				default: field <= OPT_FIELD_KIND;
			endcase
		end
	end

	// option values
	always_ff @(posedge clk) begin
		if (step) begin
			case (field)
				OPT_FIELD_KIND: cur_kind <= rx_d;
				OPT_FIELD_LEN:  data_rem <= rx_d - 8'd2;
				OPT_FIELD_DATA: begin
					opt_sr   <= opt_next[55:0];
					data_rem <= data_rem - 8'd1;
					// last value byte
					if (data_rem == 8'd1) begin
						case (cur_kind)
							OPT_MSS: mss <= opt_next[15:0];
							OPT_WIN: win_scale <= rx_d;
							OPT_SACK: begin
								opt_word.sack.sack_left  <= opt_next[63:32];
								opt_word.sack.sack_right <= opt_next[31:0];
							end
							OPT_TS: begin
								opt_word.ts.ts_val <= opt_next[63:32];
								opt_word.ts.ts_ecr <= opt_next[31:0];
							end
							default: ;
						endcase
					end
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/tcp_rx_pkg.sv
`default_nettype none

package tcp_rx_pkg;

	// ipv4 protocol number of tcp
	localparam logic [7:0] TCP_PROTO = 8'h06;

	// fixed part of the tcp header
	localparam int MIN_HDR_LEN = 20;

	// data offset nibble sits in the upper half of this byte
	localparam int OFFSET_BYTE_POS = 12;

	// option kinds
	localparam logic [7:0] OPT_END       = 8'd0;
	localparam logic [7:0] OPT_NOP       = 8'd1;
	localparam logic [7:0] OPT_MSS       = 8'd2;
	localparam logic [7:0] OPT_WIN       = 8'd3;
	localparam logic [7:0] OPT_SACK_PERM = 8'd4;
	localparam logic [7:0] OPT_SACK      = 8'd5;
	localparam logic [7:0] OPT_TS        = 8'd8;

	// option walk states
	localparam logic [1:0] OPT_FIELD_KIND = 2'd0;
	localparam logic [1:0] OPT_FIELD_LEN  = 2'd1;
	localparam logic [1:0] OPT_FIELD_DATA = 2'd2;

	// payload buffer geometry
	localparam int PL_BUF_DEPTH = 256;
	localparam int PL_ADDR_W    = 8;

	// last eight option value bytes, first received byte in the top byte
	typedef union packed {
		struct packed {
			logic [31:0] ts_val;
			logic [31:0] ts_ecr;
		} ts;
		struct packed {
			logic [31:0] sack_left;
			logic [31:0] sack_right;
		} sack;
	} opt_word_u;

endpackage

`default_nettype wire

// File: src/tcp_rx_top.sv
`default_nettype none

module tcp_rx_top (
	input  wire                              clk,
	input  wire                              fsm_rst,
	input  wire  [7:0]                       rx_d,
	input  wire                              rx_v,
	input  wire                              rx_sof,
	input  wire                              rx_eof,
	input  wire                              rx_err,
	input  wire  [7:0]                       ip_proto,
	input  wire  [15:0]                      ip_pl_len,
	input  wire  [15:0]                      local_port,
	output logic [15:0]                      src_port,
	output logic [15:0]                      dst_port,
	output logic [31:0]                      seq_num,
	output logic [31:0]                      ack_num,
	output logic [8:0]                       flags,
	output logic [15:0]                      win_size,
	output logic [15:0]                      urg_ptr,
	output logic                             mss_pres,
	output logic [15:0]                      mss,
	output logic                             win_pres,
	output logic [7:0]                       win_scale,
	output logic                             sack_perm_pres,
	output logic                             sack_pres,
	output logic [2:0]                       sack_blocks,
	output logic                             ts_pres,
	output tcp_rx_pkg::opt_word_u            opt_word,
	output logic [15:0]                      pl_len,
	output logic                             hdr_v,
	output logic                             pkt_done,
	output logic                             err,
	input  wire                              rd_req,
	input  wire  [tcp_rx_pkg::PL_ADDR_W-1:0] rd_addr,
	output logic                             rd_valid,
	output logic [7:0]                       rd_data
);

	logic                             opt_en;
	logic                             frame_clr;
	logic                             wr_req;
	logic [tcp_rx_pkg::PL_ADDR_W-1:0] wr_addr;
	logic [7:0]                       wr_data;
	logic                             mem_we;
	logic [tcp_rx_pkg::PL_ADDR_W-1:0] mem_addr;
	logic [7:0]                       mem_wdata;
	logic [7:0]                       mem_rdata;

	tcp_hdr_parser u_hdr (
		.clk        (clk),
		.fsm_rst    (fsm_rst),
		.rx_d       (rx_d),
		.rx_v       (rx_v),
		.rx_sof     (rx_sof),
		.rx_eof     (rx_eof),
		.rx_err     (rx_err),
		.ip_proto   (ip_proto),
		.ip_pl_len  (ip_pl_len),
		.local_port (local_port),
		.src_port   (src_port),
		.dst_port   (dst_port),
		.seq_num    (seq_num),
		.ack_num    (ack_num),
		.flags      (flags),
		.win_size   (win_size),
		.urg_ptr    (urg_ptr),
		.hdr_v      (hdr_v),
		.pkt_done   (pkt_done),
		.err        (err),
		.pl_len     (pl_len),
		.opt_en     (opt_en),
		.frame_clr  (frame_clr),
		.wr_req     (wr_req),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	// samples the raw stream, gated by opt_en
	tcp_opt_parser u_opt (
		.clk            (clk),
		.fsm_rst        (fsm_rst),
		.rx_d           (rx_d),
		.rx_v           (rx_v),
		.opt_en         (opt_en),
		.frame_clr      (frame_clr),
		.mss_pres       (mss_pres),
		.mss            (mss),
		.win_pres       (win_pres),
		.win_scale      (win_scale),
		.sack_perm_pres (sack_perm_pres),
		.sack_pres      (sack_pres),
		.sack_blocks    (sack_blocks),
		.ts_pres        (ts_pres),
		.opt_word       (opt_word)
	);

	pl_buf_arbiter u_arb (
		.clk       (clk),
		.fsm_rst   (fsm_rst),
		.wr_req    (wr_req),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.mem_rdata (mem_rdata),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

	pl_buf_ram u_ram (
		.clk   (clk),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

`default_nettype wire

// File: tb/tcp_rx_stim.txt
// segment: proto ip_pl_len local_port err_flag byte_count, then the bytes
// expect: hdr_v done(1)/err(2) src dst seq ack flags win urg, then options
// mss_pres mss win_pres win_scale sack_perm sack_pres sack_blocks ts_pres word_hi word_lo
7
// plain header, eight payload bytes
06 1c 1f90 0 1c
30 39 1f 90 11 22 33 44 55 66 77 88 51 18 20 00 ab cd 00 07
a0 a1 a2 a3 a4 a5 a6 a7
1 1 3039 1f90 11223344 55667788 118 2000 0007
0 0 0 0 0 0 0 0 0 0
// mss, nop, window scale, sack permitted, timestamp
06 2b 1f90 0 2b
c3 50 1f 90 00 00 10 00 00 00 20 00 a0 02 ff ff 00 00 00 00
02 04 05 b4 01 03 03 07 04 02 08 0a 01 02 03 04 05 06 07 08
b0 b1 b2
1 1 c350 1f90 00001000 00002000 002 ffff 0000
1 05b4 1 07 1 0 0 1 01020304 05060708
// two sack blocks
06 2a 1f90 0 2a
00 50 1f 90 00 00 00 01 00 00 00 02 a0 10 04 00 00 00 00 00
01 01 05 12 00 00 00 10 00 00 00 20 00 00 00 30 00 00 00 40
c0 c1
1 1 0050 1f90 00000001 00000002 010 0400 0000
0 0 0 0 0 1 2 0 00000030 00000040
// wrong destination port
06 16 1f90 0 16
30 39 1f 91 00 00 00 05 00 00 00 06 50 10 10 00 00 00 00 00 f0 f1
0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
// udp protocol
11 16 1f90 0 16
30 39 1f 90 00 00 00 05 00 00 00 06 50 10 10 00 00 00 00 00 f0 f1
0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
// eof before ip_pl_len
06 1e 1f90 0 18
04 d2 1f 90 00 00 00 07 00 00 00 08 50 18 08 00 00 00 00 00 d0 d1 d2 d3
1 2 04d2 1f90 00000007 00000008 018 0800 0000
0 0 0 0 0 0 0 0 0 0
// upstream error in mid segment
06 17 1f90 1 17
04 d3 1f 90 00 00 00 09 00 00 00 0a 50 11 08 00 00 00 00 05 e0 e1 e2
1 2 04d3 1f90 00000009 0000000a 011 0800 0005
0 0 0 0 0 0 0 0 0 0

// File: tb/tcp_rx_tb.sv
`default_nettype none

module tcp_rx_tb;
	import tcp_rx_pkg::*;

	logic clk, fsm_rst, rx_v, rx_sof, rx_eof, rx_err, rd_req;
	logic [7:0] rx_d, ip_proto, rd_data, win_scale;
	logic [15:0] ip_pl_len, local_port, pl_len, src_port, dst_port, win_size, urg_ptr, mss;
	logic [31:0] seq_num, ack_num;
	logic [8:0] flags;
	logic [2:0] sack_blocks;
	logic mss_pres, win_pres, sack_perm_pres, sack_pres, ts_pres;
	logic hdr_v, pkt_done, err, rd_valid;
	logic [PL_ADDR_W-1:0] rd_addr;
	opt_word_u opt_word;

	logic [31:0] stim [0:1023];
	logic [7:0] model [0:PL_BUF_DEPTH-1];
	logic [31:0] lfsr;
	int errors, checks, reads, valid_cnt, hdr_cnt, done_cnt, err_cnt, max_len;
	int limit_cycles;
	bit seg_fail, streaming;
	logic [15:0] pl_len_seen;

	tcp_rx_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) v = (v << 1) | next_bit();
		return v;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			$display("Fail t=%0t %s expected %h got %h", $time, name, exp, act);
			errors++;
			seg_fail = 1;
		end
	endtask

	// count output pulses where they are stable
	always @(negedge clk) begin
		if (hdr_v) hdr_cnt++;
		if (pkt_done) begin
			done_cnt++;
			pl_len_seen = pl_len;
		end
		if (err) err_cnt++;
		if (rd_valid) valid_cnt++;
	end

	// starts and ends on a falling edge
	task automatic host_read(input int addr);
		int w;
		reads++;
		rd_req = 1'b1;
		rd_addr = addr[PL_ADDR_W-1:0];
		w = 0;
		do begin
			@(negedge clk);
			w++;
		end while (!rd_valid && w < 50);
		if (!rd_valid) begin
			$display("host read at address %0d never got rd_valid", addr);
			errors++;
			seg_fail = 1;
		end else begin
			check($sformatf("rd_data[%0d]", addr), model[addr], rd_data);
		end
		rd_req = 1'b0;
		// the arbiter takes a new request only after rd_req was low
		@(negedge clk);
	endtask

	task automatic send_segment(input int base, input int nb, input bit errf);
		for (int i = 0; i < nb; i++) begin
			@(negedge clk);
			while (next_bit()) begin
				rx_v = 1'b0;
				rx_sof = 1'b0;
				rx_eof = 1'b0;
				rx_err = 1'b0;
				@(negedge clk);
			end
			rx_v = 1'b1;
			rx_d = stim[base + i][7:0];
			rx_sof = (i == 0);
			rx_eof = (i == nb - 1);
			rx_err = errf && (i == nb / 2);
		end
		@(negedge clk);
		rx_v = 1'b0;
		rx_sof = 1'b0;
		rx_eof = 1'b0;
		rx_err = 1'b0;
		streaming = 0;
	endtask

	// reads beyond the new payload while the segment streams in
	task automatic side_reads(input int lo, input int hi);
		int n;
		n = 0;
		while (streaming && n < 4) begin
			@(negedge clk);
			if (hi > lo && streaming && next_bit()) begin
				host_read(lo + take_bits(8) % (hi - lo));
				n++;
			end
		end
	endtask

	initial begin
		int p, nseg, nb, off, wrote, e, total_bytes, total_reads, run_max;
		bit match;
		fsm_rst = 1'b1;
		{rx_v, rx_sof, rx_eof, rx_err, rd_req} = '0;
		rx_d = 8'd0;
		rd_addr = '0;
		ip_proto = 8'd0;
		ip_pl_len = 16'd0;
		local_port = 16'd0;
		lfsr = 32'ha0ea378d;
		limit_cycles = 0;
		$readmemh("tb/tcp_rx_stim.txt", stim);
		nseg = stim[0];

		// run length bound from the file
		p = 1;
		total_bytes = 0;
		total_reads = 0;
		run_max = 0;
		for (int s = 0; s < nseg; s++) begin
			nb = stim[p + 4];
			off = (stim[p + 5 + 12][7:4]) * 4;
			total_bytes += nb;
			if (stim[p + 5 + nb] == 1 && nb - off > run_max) run_max = nb - off;
			total_reads += run_max + 4;
			p += 5 + nb + 19;
		end
		limit_cycles = 4 * (total_bytes + total_reads) + 200;

		repeat (8) @(negedge clk);
		fsm_rst = 1'b0;
		p = 1;
		max_len = 0;
		for (int s = 0; s < nseg; s++) begin
			seg_fail = 0;
			ip_proto = stim[p][7:0];
			ip_pl_len = stim[p + 1][15:0];
			local_port = stim[p + 2][15:0];
			nb = stim[p + 4];
			off = (stim[p + 5 + 12][7:4]) * 4;
			e = p + 5 + nb;
			match = (stim[e] == 1);
			wrote = (match && nb > off) ? nb - off : 0;
			hdr_cnt = 0;
			done_cnt = 0;
			err_cnt = 0;
			streaming = 1;
			fork
				send_segment(p + 5, nb, stim[p + 3][0]);
				side_reads(wrote, max_len);
			join
			for (int w = 0; w < 8 && done_cnt + err_cnt == 0; w++) @(negedge clk);
			if (stim[e + 1] != 0 && done_cnt + err_cnt == 0) begin
				$display("segment %0d ended without pkt_done or err", s);
				errors++;
				seg_fail = 1;
			end
			check("hdr_v count", stim[e], hdr_cnt);
			check("pkt_done count", stim[e + 1] == 1, done_cnt);
			check("err count", stim[e + 1] == 2, err_cnt);
			if (stim[e + 1] == 1) check("pl_len", ip_pl_len - off, pl_len_seen);
			if (match) begin
				check("src_port", stim[e + 2], src_port);
				check("dst_port", stim[e + 3], dst_port);
				check("seq_num", stim[e + 4], seq_num);
				check("ack_num", stim[e + 5], ack_num);
				check("flags", stim[e + 6], flags);
				check("win_size", stim[e + 7], win_size);
				check("urg_ptr", stim[e + 8], urg_ptr);
			end
			check("mss_pres", stim[e + 9], mss_pres);
			if (stim[e + 9]) check("mss", stim[e + 10], mss);
			check("win_pres", stim[e + 11], win_pres);
			if (stim[e + 11]) check("win_scale", stim[e + 12], win_scale);
			check("sack_perm_pres", stim[e + 13], sack_perm_pres);
			check("sack_pres", stim[e + 14], sack_pres);
			check("sack_blocks", stim[e + 15], sack_blocks);
			check("ts_pres", stim[e + 16], ts_pres);
			if (stim[e + 16]) begin
				check("ts_val", stim[e + 17], opt_word.ts.ts_val);
				check("ts_ecr", stim[e + 18], opt_word.ts.ts_ecr);
			end
			if (stim[e + 14]) begin
				check("sack_left", stim[e + 17], opt_word.sack.sack_left);
				check("sack_right", stim[e + 18], opt_word.sack.sack_right);
			end

			// payload lands at address 0 upward
			for (int i = 0; i < wrote; i++) model[i] = stim[p + 5 + off + i][7:0];
			if (wrote > max_len) max_len = wrote;
			for (int a = 0; a < max_len; a++) host_read(a);
			$display("test %0d: %s", s, seg_fail ? "failed" : "ok");
			p = e + 19;
			repeat (2) @(negedge clk);
		end
		check("rd_valid pulses", reads, valid_cnt);
		$display("checks %0d, errors %0d, host reads %0d", checks, errors, reads);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run hung", limit_cycles);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tcp_rx.f
src/tcp_rx_pkg.sv
src/tcp_hdr_parser.sv
src/tcp_opt_parser.sv
src/pl_buf_arbiter.sv
src/pl_buf_ram.sv
src/tcp_rx_top.sv
tb/tcp_rx_tb.sv
